// ==== dv/ifu_patterns.hex ====
// Program image by word address, count of records at @100
// Records from @101: insn pc ctl{specul_bcc[8] jmprel bcc bt jmpfar link} specul_tgt action
@000
40000000 41000000 42000000 0d000008 44000000 45000000 46000000 0afffffc
@00b
10200000
@050
90000000 91000000 92000000 93000000
@060
a0000000 a1000000 0c000004 a3000000 08000010
@074
b4000000 b5000000
@100
00000014
@101
40000000 00000000 00000000 00000000 00000000
41000000 00000001 00000000 00000001 00000000
42000000 00000002 00000000 00000002 00000000
0d000008 00000003 0000000c 0000000b 40000000
44000000 00000004 00000000 00000004 00000000
45000000 00000005 00000000 00000005 00000000
46000000 00000006 00000000 00000006 00000000
0afffffc 00000007 00000011 00000003 00000000
0d000008 00000003 0000010c 00000004 00000000
10200000 0000000b 00000002 00000050 00000000
90000000 00000050 00000000 00000050 00000000
91000000 00000051 00000000 00000051 80000060
00000000 00000052 00000000 00000052 00000000
a0000000 00000060 00000000 00000060 00000000
a1000000 00000061 00000000 00000061 00000000
0c000004 00000062 00000108 00000066 00000000
a3000000 00000063 00000000 00000063 00000000
08000010 00000064 00000010 00000074 00000000
b4000000 00000074 00000000 00000074 00000000
b5000000 00000075 00000000 00000075 00000000

// ==== dv/ifu_tb.sv ====
// Fetch unit testbench with memory model, back-pressure, flush, predictor training and checks
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_tb import ifu_pipe_pkg::*; ();

   // Pattern file layout
   localparam int COUNT_AT = 'h100;
   localparam int REC_BASE = 'h101;
   localparam int REC_W = 5;

   logic               clk;
   logic               rst;
   logic               ibus_req_valid;
   logic               ibus_req_ready;
   logic [`IFU_AW-1:0] ibus_addr;
   logic               ibus_rsp_valid;
   logic [`IFU_IW-1:0] ibus_rsp_data;
   logic               ibus_rsp_ready;
   logic               out_valid;
   fetch_pkt_t         out_pkt;
   logic               out_ready;
   logic               flush;
   logic [`IFU_PW-1:0] flush_tgt;
   bpu_upd_t           bpu_upd;

   logic [31:0]        pat [0:511];
   int                 n_exp;
   int                 n_done;
   int                 n_checks;
   int                 n_fail;
   integer             mem_seed;
   integer             rdy_seed;

   // Memory model state
   logic               req_hs;
   logic               rsp_hs;
   logic               pending;
   logic [`IFU_PW-1:0] req_word;
   int                 wait_cyc;

   ifu_top dut_i (
      .clk            (clk),
      .rst            (rst),
      .ibus_req_valid (ibus_req_valid),
      .ibus_req_ready (ibus_req_ready),
      .ibus_addr      (ibus_addr),
      .ibus_rsp_valid (ibus_rsp_valid),
      .ibus_rsp_data  (ibus_rsp_data),
      .ibus_rsp_ready (ibus_rsp_ready),
      .out_valid      (out_valid),
      .out_pkt        (out_pkt),
      .out_ready      (out_ready),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .bpu_upd        (bpu_upd)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_pkt(input int idx, input fetch_pkt_t got, input fetch_pkt_t exp);
      n_checks++;
      if (got !== exp) begin
         n_fail++;
         $display("Fail t=%0t out_pkt[%0d] got %h exp %h", $time, idx, got, exp);
      end else begin
         $display("ok   packet %0d pc %h insn %h", idx, got.pc, got.insn);
      end
   endtask

   task automatic check_addr(input string name, input logic [`IFU_AW-1:0] got,
                             input logic [`IFU_AW-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_fail++;
         $display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
      end else begin
         $display("ok   %s %h", name, got);
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_fail++;
         $display("Fail t=%0t %s got %0d exp %0d", $time, name, got, exp);
      end else begin
         $display("ok   %s %0d cycles", name, got);
      end
   endtask

   // Expected packet from one record
   function automatic fetch_pkt_t load_expected(input int base);
      fetch_pkt_t  p;
      logic [31:0] ctl;
      ctl          = pat[base+2];
      p.insn       = pat[base];
      p.pc         = pat[base+1][`IFU_PW-1:0];
      p.op_jmprel  = ctl[4];
      p.op_bcc     = ctl[3];
      p.op_bt      = ctl[2];
      p.op_jmpfar  = ctl[1];
      p.link       = ctl[0];
      p.specul_tgt = pat[base+3][`IFU_PW-1:0];
      p.specul_bcc = ctl[8];
      return p;
   endfunction

   // Random ready until one packet is taken, then hold
   task automatic take_pkt(output fetch_pkt_t p);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         @(posedge clk);
         #1;
         out_ready = (($random(rdy_seed) & 3) != 0);
         @(negedge clk);
         if (out_valid && out_ready) begin
            p = out_pkt;
            taken = 1'b1;
         end
      end
      @(posedge clk);
      #1;
      out_ready = 1'b0;
   endtask

   // Two taken outcomes push the counter to strongly taken
   task automatic train_taken(input logic [`IFU_PW-1:0] pc);
      bpu_upd.valid = 1'b1;
      bpu_upd.pc    = pc;
      bpu_upd.taken = 1'b1;
      repeat (2) begin
         @(posedge clk);
         #1;
      end
      bpu_upd = '0;
   endtask

   // Flush while the next packet sits stalled in the buffer
   task automatic apply_flush(input logic [`IFU_PW-1:0] tgt);
      while (!out_valid) begin
         @(posedge clk);
         #1;
      end
      flush     = 1'b1;
      flush_tgt = tgt;
      @(posedge clk);
      #1;
      flush = 1'b0;
   endtask

   // Answers each request after 1 to 3 cycles
   initial begin
      mem_seed       = 32'hf321aa36;
      ibus_req_ready = 1'b0;
      ibus_rsp_valid = 1'b0;
      ibus_rsp_data  = '0;
      pending        = 1'b0;
      wait_cyc       = 0;
      req_word       = '0;
      forever begin
         @(negedge clk);
         req_hs = ibus_req_valid && ibus_req_ready;
         rsp_hs = ibus_rsp_valid && ibus_rsp_ready;
         if (req_hs) begin
            req_word = ibus_addr[`IFU_AW-1:2];
         end
         @(posedge clk);
         #1;
         if (rst) begin
            ibus_rsp_valid = 1'b0;
            pending        = 1'b0;
         end else begin
            if (rsp_hs) begin
               ibus_rsp_valid = 1'b0;
            end
            if (req_hs) begin
               pending  = 1'b1;
               wait_cyc = $unsigned($random(mem_seed)) % 3;
            end
            if (pending) begin
               if (wait_cyc == 0) begin
                  ibus_rsp_valid = 1'b1;
                  ibus_rsp_data  = pat[{1'b0, req_word[7:0]}];
                  pending        = 1'b0;
               end else begin
                  wait_cyc--;
               end
            end
         end
         ibus_req_ready = (($random(mem_seed) & 1) != 0);
      end
   end

   // Budget of 200 cycles per expected packet from reset release
   initial begin
      @(negedge rst);
      repeat (n_exp * 200 + 10 + `IFU_RESET_WAIT) @(posedge clk);
      $display("Watchdog expired with %0d of %0d packets received", n_done, n_exp);
      $display("Test failures found");
      $finish;
   end

   initial begin
      int          a;
      int          base;
      int          wait_cnt;
      fetch_pkt_t  exp_pkt;
      fetch_pkt_t  got_pkt;
      logic [31:0] act;
      rdy_seed  = 32'hf321aa36;
      n_done    = 0;
      n_checks  = 0;
      n_fail    = 0;
      rst       = 1'b1;
      out_ready = 1'b0;
      flush     = 1'b0;
      flush_tgt = '0;
      bpu_upd   = '0;
      // Unused words read as non-branch fillers
      for (a = 0; a < 512; a++) begin
         pat[a] = {8'hf0, 15'h0, 9'(a)};
      end
      $readmemh("dv/ifu_patterns.hex", pat);
      n_exp = pat[COUNT_AT];
      // Record count must fit the pattern memory
      if (n_exp <= 0 || n_exp > (512 - REC_BASE) / REC_W) begin
         $display("Pattern file holds an invalid record count %0d", n_exp);
         n_fail++;
         n_exp = 0;
      end

      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      // Idle cycles before the first request
      wait_cnt = 0;
      @(negedge clk);
      while (!ibus_req_valid) begin
         wait_cnt++;
         @(negedge clk);
      end
      check_cycles("reset wait", wait_cnt, `IFU_RESET_WAIT);
      check_addr("ibus_addr", ibus_addr, '0);

      for (int i = 0; i < n_exp; i++) begin
         base    = REC_BASE + i * REC_W;
         exp_pkt = load_expected(base);
         take_pkt(got_pkt);
         n_done++;
         check_pkt(i, got_pkt, exp_pkt);
         // Top bits of the action word pick training (1) or flush (2)
         act = pat[base+4];
         if (act[31:30] == 2'd1) begin
            train_taken(exp_pkt.pc);
         end else if (act[31:30] == 2'd2) begin
            apply_flush(act[`IFU_PW-1:0]);
         end
      end

      $display("%0d checks run, %0d failed", n_checks, n_fail);
      if (n_fail == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+include
hw/ifu_insn_pkg.sv
hw/ifu_pipe_pkg.sv
hw/ifu_reset_timer.sv
hw/ifu_fetch_fsm.sv
hw/ifu_predecoder.sv
hw/ifu_bpu.sv
hw/ifu_pipebuf.sv
hw/ifu_top.sv
dv/ifu_tb.sv

// ==== hw/ifu_bpu.sv ====
// Branch predictor with 2-bit counters, update port and far-jump target table
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_bpu import ifu_pipe_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`IFU_PW-1:0]        rd_pc,
   input  logic [`IFU_FAR_IDX_W-1:0] far_idx,
   input  bpu_upd_t                  upd,
   output logic                      taken,
   output logic [`IFU_PW-1:0]        far_tgt
);

   localparam int ENTRIES = 1 << `IFU_BPU_IDX_W;

   logic [1:0]                cnt_q [ENTRIES];
   logic [`IFU_BPU_IDX_W-1:0] rd_idx;
   logic [`IFU_BPU_IDX_W-1:0] upd_idx;

   // Direct-mapped on the low pc bits
   assign rd_idx = rd_pc[`IFU_BPU_IDX_W-1:0];
   assign upd_idx = upd.pc[`IFU_BPU_IDX_W-1:0];

   // MSB of the counter is the prediction
   assign taken = cnt_q[rd_idx][1];

   always_ff @(posedge clk) begin
      if (rst) begin
         // Weakly not-taken
         for (int i = 0; i < ENTRIES; i++) begin
            cnt_q[i] <= 2'b01;
         end
      end else if (upd.valid) begin
         if (upd.taken && cnt_q[upd_idx] != 2'b11) begin
            cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
         end else if (!upd.taken && cnt_q[upd_idx] != 2'b00) begin
            cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
         end
      end
   end

   // Fixed far targets
   always_comb begin
      case (far_idx)
         2'd0:    far_tgt = `IFU_FAR_TGT0;
         2'd1:    far_tgt = `IFU_FAR_TGT1;
         2'd2:    far_tgt = `IFU_FAR_TGT2;
         default: far_tgt = `IFU_FAR_TGT3;
      endcase
   end

endmodule

// ==== hw/ifu_fetch_fsm.sv ====
// Fetch FSM with pc register, next-pc select, bus handshake and flush redirect
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_fetch_fsm import ifu_insn_pkg::*, ifu_pipe_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               start_ok,
   input  logic               ibus_req_ready,
   input  logic               ibus_rsp_valid,
   input  logic               buf_ready,
   input  predec_t            predec,
   input  logic               bpu_taken,
   input  logic [`IFU_PW-1:0] far_tgt,
   input  logic               flush,
   input  logic [`IFU_PW-1:0] flush_tgt,
   output logic               ibus_req_valid,
   output logic [`IFU_AW-1:0] ibus_addr,
   output logic               ibus_rsp_ready,
   output logic               cap,
   output logic [`IFU_PW-1:0] cur_pc
);

   fetch_state_e       state_q;
   fetch_state_e       state_nxt;
   logic [`IFU_PW-1:0] pc_q;
   logic [`IFU_PW-1:0] pc_nxt;
   // Outstanding response belongs to a flushed path
   logic               drop_q;
   logic               req_fire;
   logic               rsp_fire;
   logic               rel_taken;

   assign req_fire = ibus_req_valid && ibus_req_ready;
   assign rsp_fire = ibus_rsp_valid && ibus_rsp_ready;

   // Stale or flushed responses are swallowed without waiting on the buffer
   assign ibus_rsp_ready = (state_q == AWAIT_RESP) && (drop_q || flush || buf_ready);
   assign cap = rsp_fire && !drop_q && !flush;

   // Unconditional, or conditional and predicted taken
   assign rel_taken = predec.op_jmprel || (predec.op_bcc && bpu_taken);

   // Priority: flush, far, predicted relative, sequential
   always_comb begin
      if (flush) begin
         pc_nxt = flush_tgt;
      end else if (predec.op_jmpfar) begin
         pc_nxt = far_tgt;
      end else if (rel_taken) begin
         pc_nxt = predec.rel_tgt;
      end else begin
         pc_nxt = pc_q + 1'b1;
      end
   end

   // Next request leaves in the same cycle as the captured response
   assign ibus_req_valid = (state_q == ISSUE) || cap;
   assign ibus_addr = {(state_q == AWAIT_RESP) ? pc_nxt : pc_q, 2'b00};
   assign cur_pc = pc_q;

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         WAIT_RESET: if (start_ok) state_nxt = ISSUE;
         ISSUE:      if (req_fire) state_nxt = AWAIT_RESP;
         AWAIT_RESP: if (rsp_fire) state_nxt = req_fire ? AWAIT_RESP : ISSUE;
         default:    state_nxt = WAIT_RESET;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= WAIT_RESET;
         pc_q    <= '0;
         drop_q  <= 1'b0;
      end else begin
         state_q <= state_nxt;
         if (flush || cap) begin
            pc_q <= pc_nxt;
         end
         // Set when flush hits an accepted request still in flight
         if (rsp_fire) begin
            drop_q <= 1'b0;
         end else if (flush && (state_q == AWAIT_RESP || req_fire)) begin
            drop_q <= 1'b1;
         end
      end
   end

   // Request held with a steady address until accepted
   a_req_hold: assert property (@(posedge clk) disable iff (rst)
      ibus_req_valid && !ibus_req_ready && !flush |=> ibus_req_valid && $stable(ibus_addr));

   // No bus traffic before the reset timer has run out
   a_no_early_issue: assert property (@(posedge clk) disable iff (rst)
      !start_ok |-> !ibus_req_valid);

endmodule

// ==== hw/ifu_insn_pkg.sv ====
// Instruction formats, instruction word union and predecode result struct
`include "ifu_consts.svh"

package ifu_insn_pkg;

   // Relative format, jumps and conditional branches
   typedef struct packed {
      logic [`IFU_OPW-1:0]          opcode;
      logic                         link;
      // Branch if condition true
      logic                         sense;
      logic signed [`IFU_OFS_W-1:0] offset;
   } insn_rel_t;

   // Register format, far jumps
   typedef struct packed {
      logic [`IFU_OPW-1:0]                       opcode;
      logic [`IFU_REG_W-1:0]                     rs;
      logic [`IFU_IW-`IFU_OPW-`IFU_REG_W-1:0]    spare;
   } insn_reg_t;

   // Same word, two views
   typedef union packed {
      insn_rel_t rel;
      insn_reg_t rg;
   } insn_u;

   typedef struct packed {
      logic                      op_jmprel;
      logic                      op_bcc;
      logic                      op_bt;
      logic                      op_jmpfar;
      logic                      link;
      logic [`IFU_FAR_IDX_W-1:0] far_idx;
      logic [`IFU_PW-1:0]        rel_tgt;
   } predec_t;

endpackage

// ==== hw/ifu_pipe_pkg.sv ====
// Fetch state enum, predictor update struct and decoder-bound fetch packet
`include "ifu_consts.svh"

package ifu_pipe_pkg;

   typedef enum logic [1:0] {WAIT_RESET, ISSUE, AWAIT_RESP} fetch_state_e;

   // Resolved branch outcome from a later stage
   typedef struct packed {
      logic               valid;
      logic [`IFU_PW-1:0] pc;
      logic               taken;
   } bpu_upd_t;

   typedef struct packed {
      logic [`IFU_IW-1:0] insn;
      logic [`IFU_PW-1:0] pc;
      logic               op_jmprel;
      logic               op_bcc;
      logic               op_bt;
      logic               op_jmpfar;
      logic               link;
      // Alternate path for mispredict recovery
      logic [`IFU_PW-1:0] specul_tgt;
      logic               specul_bcc;
   } fetch_pkt_t;

endpackage

// ==== hw/ifu_pipebuf.sv ====
// One-entry valid/ready register for the fetch packet, with flush to nop
`timescale 1ns/1ps

module ifu_pipebuf import ifu_pipe_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       in_valid,
   input  fetch_pkt_t in_pkt,
   input  logic       flush,
   input  logic       out_ready,
   output logic       in_ready,
   output logic       out_valid,
   output fetch_pkt_t out_pkt
);

   fetch_pkt_t pkt_q;
   fetch_pkt_t pkt_nxt;
   logic       valid_q;
   logic       load;

   // Bubble keeps pc and targets but drops instruction and flags
   function automatic fetch_pkt_t to_nop(input fetch_pkt_t p);
      fetch_pkt_t n;
      n            = p;
      n.insn       = '0;
      n.op_jmprel  = 1'b0;
      n.op_bcc     = 1'b0;
      n.op_bt      = 1'b0;
      n.op_jmpfar  = 1'b0;
      n.link       = 1'b0;
      n.specul_bcc = 1'b0;
      return n;
   endfunction

   // Accept when empty or draining this cycle
   assign in_ready = !valid_q || out_ready;
   assign load = in_valid && in_ready;

   assign out_valid = valid_q;
   // Bubble shows up already in the flush cycle
   assign out_pkt = flush ? to_nop(pkt_q) : pkt_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   assign pkt_nxt = load ? in_pkt : pkt_q;

   always_ff @(posedge clk) begin
      pkt_q <= flush ? to_nop(pkt_nxt) : pkt_nxt;
   end

   // Stalled packet stays put unless flushed
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && (flush || $stable(out_pkt)));

endmodule

// ==== hw/ifu_predecoder.sv ====
// Predecoder classifying a fetched word and forming its relative target
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_predecoder import ifu_insn_pkg::*; (
   input  insn_u              insn,
   input  logic [`IFU_PW-1:0] pc,
   output predec_t            predec
);

   logic [`IFU_OPW-1:0] op;
   logic [`IFU_PW-1:0]  ofs_ext;
   logic                is_bcc;

   // Opcode sits in the same place in both formats
   assign op = insn.rel.opcode;
   assign is_bcc = (op == `IFU_OP_BCC);

   // Word offset sign-extended to pc width
   assign ofs_ext = {{(`IFU_PW-`IFU_OFS_W){insn.rel.offset[`IFU_OFS_W-1]}},
                     insn.rel.offset};

   always_comb begin
      predec.op_jmprel = (op == `IFU_OP_JMPREL);
      predec.op_bcc    = is_bcc;
      // Sense bit only means something on a conditional branch
      predec.op_bt     = is_bcc && insn.rel.sense;
      predec.op_jmpfar = (op == `IFU_OP_JMPFAR);
      // Link on relative jumps only
      predec.link      = predec.op_jmprel && insn.rel.link;
      // Register view picks the far table slot
      predec.far_idx   = insn.rg.rs[`IFU_FAR_IDX_W-1:0];
      predec.rel_tgt   = pc + ofs_ext;
   end

endmodule

// ==== hw/ifu_reset_timer.sv ====
// Reset wait timer, holds fetch off for a fixed number of cycles
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_reset_timer (
   input  logic clk,
   input  logic rst,
   output logic done
);

   // FSM leaves WAIT_RESET one edge after done
   localparam int LIMIT = `IFU_RESET_WAIT - 1;
   localparam int CW = $clog2(`IFU_RESET_WAIT + 1);

   logic [CW-1:0] cnt_q;

   // Saturates at the limit
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt_q <= '0;
      end else if (!done) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign done = (cnt_q == CW'(LIMIT));

endmodule

// ==== hw/ifu_top.sv ====
// Fetch unit top connecting timer, FSM, predecoder, predictor and pipe register
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_top import ifu_insn_pkg::*, ifu_pipe_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   // Instruction bus
   output logic               ibus_req_valid,
   input  logic               ibus_req_ready,
   output logic [`IFU_AW-1:0] ibus_addr,
   input  logic               ibus_rsp_valid,
   input  logic [`IFU_IW-1:0] ibus_rsp_data,
   output logic               ibus_rsp_ready,
   // Decoder side
   output logic               out_valid,
   output fetch_pkt_t         out_pkt,
   input  logic               out_ready,
   // Later stage
   input  logic               flush,
   input  logic [`IFU_PW-1:0] flush_tgt,
   input  bpu_upd_t           bpu_upd
);

   logic               start_ok;
   logic               buf_ready;
   logic               cap;
   logic [`IFU_PW-1:0] cur_pc;
   predec_t            predec;
   logic               bpu_taken;
   logic [`IFU_PW-1:0] far_tgt;
   logic               pred_taken;
   fetch_pkt_t         in_pkt;

   ifu_reset_timer u_timer (
      .clk  (clk),
      .rst  (rst),
      .done (start_ok)
   );

   ifu_fetch_fsm u_fsm (
      .clk            (clk),
      .rst            (rst),
      .start_ok       (start_ok),
      .ibus_req_ready (ibus_req_ready),
      .ibus_rsp_valid (ibus_rsp_valid),
      .buf_ready      (buf_ready),
      .predec         (predec),
      .bpu_taken      (bpu_taken),
      .far_tgt        (far_tgt),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .ibus_req_valid (ibus_req_valid),
      .ibus_addr      (ibus_addr),
      .ibus_rsp_ready (ibus_rsp_ready),
      .cap            (cap),
      .cur_pc         (cur_pc)
   );

   // Response word decoded against the pc it was fetched from
   ifu_predecoder u_predec (
      .insn   (insn_u'(ibus_rsp_data)),
      .pc     (cur_pc),
      .predec (predec)
   );

   ifu_bpu u_bpu (
      .clk     (clk),
      .rst     (rst),
      .rd_pc   (cur_pc),
      .far_idx (predec.far_idx),
      .upd     (bpu_upd),
      .taken   (bpu_taken),
      .far_tgt (far_tgt)
   );

   assign pred_taken = predec.op_bcc && bpu_taken;

   // Packet assembly
   always_comb begin
      in_pkt.insn      = ibus_rsp_data;
      in_pkt.pc        = cur_pc;
      in_pkt.op_jmprel = predec.op_jmprel;
      in_pkt.op_bcc    = predec.op_bcc;
      in_pkt.op_bt     = predec.op_bt;
      in_pkt.op_jmpfar = predec.op_jmpfar;
      in_pkt.link      = predec.link;
      // Far jump carries its predicted target, branches the path not taken
      if (predec.op_jmpfar) begin
         in_pkt.specul_tgt = far_tgt;
      end else if (pred_taken) begin
         in_pkt.specul_tgt = cur_pc + 1'b1;
      end else begin
         in_pkt.specul_tgt = predec.rel_tgt;
      end
      // Condition flag value implied by the prediction
      in_pkt.specul_bcc = predec.op_bcc && (bpu_taken == predec.op_bt);
   end

   ifu_pipebuf u_buf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (cap),
      .in_pkt    (in_pkt),
      .flush     (flush),
      .out_ready (out_ready),
      .in_ready  (buf_ready),
      .out_valid (out_valid),
      .out_pkt   (out_pkt)
   );

endmodule

// ==== include/ifu_consts.svh ====
// Fetch unit widths, opcodes, reset wait, table sizes and far-jump targets
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Byte address, word pc and instruction widths
`define IFU_AW 32
`define IFU_PW (`IFU_AW-2)
`define IFU_IW 32

// Instruction field widths
`define IFU_OPW 6
`define IFU_OFS_W 24
`define IFU_REG_W 5

// Opcodes, zero decodes as a plain nop
`define IFU_OP_JMPREL 6'h02
`define IFU_OP_BCC 6'h03
`define IFU_OP_JMPFAR 6'h04

// Idle cycles after reset before the first request
`define IFU_RESET_WAIT 3

// Counter table index bits, far table index bits
`define IFU_BPU_IDX_W 4
`define IFU_FAR_IDX_W 2

// Far-jump table, word targets selected by register field
`define IFU_FAR_TGT0 30'h0000_0040
`define IFU_FAR_TGT1 30'h0000_0050
`define IFU_FAR_TGT2 30'h0000_0060
`define IFU_FAR_TGT3 30'h0000_0070

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ifu_tb -o ifu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ifu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
